// File: logic/video_pkg.sv
`default_nettype none

package video_pkg;

	// four 4-bit pixels, leftmost pixel in the top nibble
	typedef logic [15:0] word_t;

	// rgb555
	typedef logic [14:0] color_t;

	typedef logic [7:0] pix_idx_t;
	typedef logic [20:0] dram_addr_t;
	typedef logic [2:0] reg_addr_t;

	// port register map
	localparam reg_addr_t reg_border    = 3'd0;
	localparam reg_addr_t reg_vpage     = 3'd1;
	localparam reg_addr_t reg_palsel    = 3'd2;
	localparam reg_addr_t reg_gy_offsl  = 3'd3;
	localparam reg_addr_t reg_gy_offsh  = 3'd4;
	localparam reg_addr_t reg_hint_beg  = 3'd5;
	localparam reg_addr_t reg_vint_begl = 3'd6;
	localparam reg_addr_t reg_vint_begh = 3'd7;

	// words per row in a video page
	localparam int row_words_log2 = 6;

endpackage

`default_nettype wire

// File: logic/video_ports.sv
`default_nettype none

module video_ports (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic port_wr,
	input wire video_pkg::reg_addr_t port_addr,
	input wire logic [7:0] port_data,
	output video_pkg::pix_idx_t border,
	output logic [7:0] vpage,
	output logic [3:0] palsel,
	output logic [8:0] gy_offs,
	output logic [7:0] hint_beg,
	output logic [8:0] vint_beg
);

	import video_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			border <= '0;
			vpage <= '0;
			palsel <= '0;
			gy_offs <= '0;
			hint_beg <= '0;
			vint_beg <= '0;
		end else if (port_wr) begin
			case (port_addr)
				reg_border: border <= port_data;
				reg_vpage: vpage <= port_data;
				reg_palsel: palsel <= port_data[3:0];
				// 9-bit values come in two writes
				reg_gy_offsl: gy_offs[7:0] <= port_data;
				reg_gy_offsh: gy_offs[8] <= port_data[0];
				reg_hint_beg: hint_beg <= port_data;
				reg_vint_begl: vint_beg[7:0] <= port_data;
				reg_vint_begh: vint_beg[8] <= port_data[0];
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/video_sync.sv
`default_nettype none

module video_sync #(
	parameter int h_active = 32,
	parameter int h_total = 48,
	parameter int hsync_beg = 36,
	parameter int hsync_len = 4,
	parameter int v_active = 8,
	parameter int v_total = 12,
	parameter int vsync_beg = 9,
	parameter int vsync_len = 2
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [7:0] hint_beg,
	input wire logic [8:0] vint_beg,
	output logic [5:0] hcount,
	output logic [3:0] vcount,
	output logic active,
	output logic line_start,
	output logic hsync,
	output logic vsync,
	output logic int_start
);

	logic [5:0] h_nxt;
	logic [3:0] v_nxt;

	// position after the coming edge
	always_comb begin
		if (hcount == 6'(h_total - 1)) begin
			h_nxt = '0;
			v_nxt = (vcount == 4'(v_total - 1)) ? 4'd0 : vcount + 4'd1;
		end else begin
			h_nxt = hcount + 6'd1;
			v_nxt = vcount;
		end
	end

	// flags come from the next position so they sit with the counters
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// parked on the last position, first edge out of reset wraps to 0,0
			hcount <= 6'(h_total - 1);
			vcount <= 4'(v_total - 1);
			active <= 1'b0;
			line_start <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			int_start <= 1'b0;
		end else begin
			hcount <= h_nxt;
			vcount <= v_nxt;
			active <= (int'(h_nxt) < h_active) && (int'(v_nxt) < v_active);
			line_start <= (h_nxt == 6'd0);
			hsync <= !((int'(h_nxt) >= hsync_beg) && (int'(h_nxt) < hsync_beg + hsync_len));
			vsync <= !((int'(v_nxt) >= vsync_beg) && (int'(v_nxt) < vsync_beg + vsync_len));
			int_start <= ({2'b00, h_nxt} == hint_beg) && ({5'd0, v_nxt} == vint_beg);
		end
	end

endmodule

`default_nettype wire

// File: logic/video_fetch.sv
`default_nettype none

module video_fetch #(
	parameter int h_active = 32,
	parameter int v_active = 8,
	parameter int v_total = 12
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic line_start,
	input wire logic [3:0] vcount,
	input wire logic [7:0] vpage,
	input wire logic [8:0] gy_offs,
	output video_pkg::dram_addr_t video_addr,
	output logic video_go,
	input wire logic video_next,
	input wire video_pkg::word_t dram_rdata,
	output logic [3:0] lb_waddr,
	output video_pkg::word_t lb_wdata,
	output logic lb_we
);

	import video_pkg::*;

	localparam int words = h_active / 4;
	localparam int word_bits = $clog2(words);

	typedef enum logic {
		fs_idle,
		fs_read
	} fstate_t;

	fstate_t state;
	logic [row_words_log2-1:0] k;
	logic [3:0] nxt;
	logic [5:0] page_q;
	logic [8:0] row_q;
	logic bank_q;

	// line that follows the current one
	assign nxt = (vcount == 4'(v_total - 1)) ? 4'd0 : vcount + 4'd1;

	assign video_go = (state == fs_read);
	assign video_addr = {page_q, row_q, k};

	// returned word goes straight into the back bank
	assign lb_we = video_go && video_next;
	assign lb_waddr = 4'({bank_q, k[word_bits-1:0]});
	assign lb_wdata = dram_rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= fs_idle;
			k <= '0;
		end else if (line_start) begin
			// new line drops whatever was left of the old one
			k <= '0;
			state <= (int'(nxt) < v_active) ? fs_read : fs_idle;
		end else if (video_go && video_next) begin
			if (k == row_words_log2'(words - 1))
				state <= fs_idle;
			else
				k <= k + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (line_start) begin
			page_q <= vpage[5:0];
			row_q <= gy_offs + 9'(nxt);
			bank_q <= nxt[0];
		end
	end

endmodule

`default_nettype wire

// File: logic/video_dpram.sv
`default_nettype none

module video_dpram #(
	parameter type payload_t = logic [15:0],
	parameter int addr_width = 4
) (
	input wire logic clk,
	input wire logic we,
	input wire logic [addr_width-1:0] waddr,
	input wire payload_t wdata,
	input wire logic [addr_width-1:0] raddr,
	output payload_t rdata
);

	payload_t mem [2**addr_width];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// File: logic/video_render.sv
`default_nettype none

module video_render #(
	parameter int h_active = 32
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [5:0] hcount,
	input wire logic [3:0] vcount,
	input wire logic active,
	input wire logic line_start,
	input wire video_pkg::pix_idx_t border,
	input wire logic [3:0] palsel,
	output logic [3:0] lb_raddr,
	input wire video_pkg::word_t lb_rdata,
	output video_pkg::pix_idx_t pix_idx
);

	import video_pkg::*;

	localparam int word_bits = $clog2(h_active / 4);

	logic [3:0] palsel_q;
	logic act_d;
	logic [1:0] nib_sel;
	pix_idx_t border_d;
	logic [3:0] nibble;

	// front bank is the one matching the displayed line
	assign lb_raddr = 4'({vcount[0], hcount[word_bits+1:2]});

	always_comb begin
		case (nib_sel)
			2'd0: nibble = lb_rdata[15:12];
			2'd1: nibble = lb_rdata[11:8];
			2'd2: nibble = lb_rdata[7:4];
			default: nibble = lb_rdata[3:0];
		endcase
	end

	// one stage to line up with the ram read
	always_ff @(posedge clk) begin
		nib_sel <= hcount[1:0];
		border_d <= border;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			palsel_q <= '0;
			act_d <= 1'b0;
			pix_idx <= '0;
		end else begin
			if (line_start)
				palsel_q <= palsel;
			act_d <= active;
			pix_idx <= act_d ? {palsel_q, nibble} : border_d;
		end
	end

endmodule

`default_nettype wire

// File: logic/video_out.sv
`default_nettype none

module video_out (
	input wire logic clk,
	input wire logic rst_n,
	input wire video_pkg::pix_idx_t pix_idx,
	input wire logic hsync_in,
	input wire logic vsync_in,
	output video_pkg::pix_idx_t cram_raddr,
	input wire video_pkg::color_t cram_rdata,
	output logic [1:0] vred,
	output logic [1:0] vgrn,
	output logic [1:0] vblu,
	output logic hsync,
	output logic vsync
);

	logic [3:0] hs_d;
	logic [3:0] vs_d;
	logic [3:0] vld_d;
	logic show;

	assign cram_raddr = pix_idx;

	// syncs ride along with the render and palette stages
	assign hsync = hs_d[3];
	assign vsync = vs_d[3];

	// the warm-up bit trails the sync taps by one, so the first
	// counter cycle is the first one that reaches the dac
	assign show = vld_d[3] && hs_d[2] && vs_d[2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hs_d <= '1;
			vs_d <= '1;
			vld_d <= '0;
			vred <= '0;
			vgrn <= '0;
			vblu <= '0;
		end else begin
			hs_d <= {hs_d[2:0], hsync_in};
			vs_d <= {vs_d[2:0], vsync_in};
			vld_d <= {vld_d[2:0], 1'b1};
			vred <= show ? cram_rdata[14:13] : 2'b00;
			vgrn <= show ? cram_rdata[9:8] : 2'b00;
			vblu <= show ? cram_rdata[4:3] : 2'b00;
		end
	end

endmodule

`default_nettype wire

// File: logic/video_top.sv
`default_nettype none

module video_top #(
	parameter int h_active = 32,
	parameter int h_total = 48,
	parameter int hsync_beg = 36,
	parameter int hsync_len = 4,
	parameter int v_active = 8,
	parameter int v_total = 12,
	parameter int vsync_beg = 9,
	parameter int vsync_len = 2
) (
	input wire logic clk,
	input wire logic rst_n,

	// host side
	input wire logic port_wr,
	input wire video_pkg::reg_addr_t port_addr,
	input wire logic [7:0] port_data,
	input wire logic cram_we,
	input wire video_pkg::pix_idx_t cram_addr,
	input wire video_pkg::color_t cram_data,

	// dram
	output video_pkg::dram_addr_t video_addr,
	output logic video_go,
	input wire logic video_next,
	input wire video_pkg::word_t dram_rdata,

	// dac and syncs
	output logic [1:0] vred,
	output logic [1:0] vgrn,
	output logic [1:0] vblu,
	output logic hsync,
	output logic vsync,
	output logic int_start
);

	import video_pkg::*;

	pix_idx_t border;
	logic [7:0] vpage;
	logic [3:0] palsel;
	logic [8:0] gy_offs;
	logic [7:0] hint_beg;
	logic [8:0] vint_beg;

	logic [5:0] hcount;
	logic [3:0] vcount;
	logic active;
	logic line_start;
	logic hsync_int;
	logic vsync_int;

	logic [3:0] lb_waddr;
	logic [3:0] lb_raddr;
	word_t lb_wdata;
	word_t lb_rdata;
	logic lb_we;

	pix_idx_t pix_idx;
	pix_idx_t cram_raddr;
	color_t cram_rdata;

	video_ports video_ports (
		.clk       (clk),
		.rst_n     (rst_n),
		.port_wr   (port_wr),
		.port_addr (port_addr),
		.port_data (port_data),
		.border    (border),
		.vpage     (vpage),
		.palsel    (palsel),
		.gy_offs   (gy_offs),
		.hint_beg  (hint_beg),
		.vint_beg  (vint_beg)
	);

	video_sync #(
		.h_active  (h_active),
		.h_total   (h_total),
		.hsync_beg (hsync_beg),
		.hsync_len (hsync_len),
		.v_active  (v_active),
		.v_total   (v_total),
		.vsync_beg (vsync_beg),
		.vsync_len (vsync_len)
	) video_sync (
		.clk        (clk),
		.rst_n      (rst_n),
		.hint_beg   (hint_beg),
		.vint_beg   (vint_beg),
		.hcount     (hcount),
		.vcount     (vcount),
		.active     (active),
		.line_start (line_start),
		.hsync      (hsync_int),
		.vsync      (vsync_int),
		.int_start  (int_start)
	);

	video_fetch #(
		.h_active (h_active),
		.v_active (v_active),
		.v_total  (v_total)
	) video_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_start (line_start),
		.vcount     (vcount),
		.vpage      (vpage),
		.gy_offs    (gy_offs),
		.video_addr (video_addr),
		.video_go   (video_go),
		.video_next (video_next),
		.dram_rdata (dram_rdata),
		.lb_waddr   (lb_waddr),
		.lb_wdata   (lb_wdata),
		.lb_we      (lb_we)
	);

	// ping-pong line buffer, bank in the top address bit
	video_dpram #(
		.payload_t  (word_t),
		.addr_width (4)
	) video_linebuf (
		.clk   (clk),
		.we    (lb_we),
		.waddr (lb_waddr),
		.wdata (lb_wdata),
		.raddr (lb_raddr),
		.rdata (lb_rdata)
	);

	video_render #(
		.h_active (h_active)
	) video_render (
		.clk        (clk),
		.rst_n      (rst_n),
		.hcount     (hcount),
		.vcount     (vcount),
		.active     (active),
		.line_start (line_start),
		.border     (border),
		.palsel     (palsel),
		.lb_raddr   (lb_raddr),
		.lb_rdata   (lb_rdata),
		.pix_idx    (pix_idx)
	);

	video_dpram #(
		.payload_t  (color_t),
		.addr_width (8)
	) video_cram (
		.clk   (clk),
		.we    (cram_we),
		.waddr (cram_addr),
		.wdata (cram_data),
		.raddr (cram_raddr),
		.rdata (cram_rdata)
	);

	video_out video_out (
		.clk        (clk),
		.rst_n      (rst_n),
		.pix_idx    (pix_idx),
		.hsync_in   (hsync_int),
		.vsync_in   (vsync_int),
		.cram_raddr (cram_raddr),
		.cram_rdata (cram_rdata),
		.vred       (vred),
		.vgrn       (vgrn),
		.vblu       (vblu),
		.hsync      (hsync),
		.vsync      (vsync)
	);

endmodule

`default_nettype wire

// File: testbench/tb_video_top.sv
`default_nettype none

module tb_video_top;

	import video_pkg::*;

	localparam int h_active = 32;
	localparam int h_total = 48;
	localparam int hsync_beg = 36;
	localparam int hsync_len = 4;
	localparam int v_active = 8;
	localparam int v_total = 12;
	localparam int vsync_beg = 9;
	localparam int vsync_len = 2;
	localparam int frame_cycles = h_total * v_total;
	localparam int cycle_limit = 8 * frame_cycles;

	logic clk = 1'b0;
	logic rst_n;
	logic port_wr;
	reg_addr_t port_addr;
	logic [7:0] port_data;
	logic cram_we;
	pix_idx_t cram_addr;
	color_t cram_data;
	dram_addr_t video_addr;
	logic video_go;
	logic video_next = 1'b0;
	word_t dram_rdata = '0;
	logic [1:0] vred;
	logic [1:0] vgrn;
	logic [1:0] vblu;
	logic hsync;
	logic vsync;
	logic int_start;

	// register copies kept by the testbench
	pix_idx_t border_sh = '0;
	logic [7:0] vpage_sh = '0;
	logic [3:0] palsel_sh = '0;
	logic [8:0] gy_sh = '0;
	logic [7:0] hint_sh = '0;
	logic [8:0] vint_sh = '0;
	logic [7:0] hint_seen = '0;
	logic [8:0] vint_seen = '0;

	int pos = -1;
	bit armed = 1'b0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int pulses [8];
	color_t col_q [$];
	color_t snap [h_active * v_active];
	bit pending = 1'b0;
	int wait_cnt = 0;
	int w;
	int fv;
	int fetch_k = 0;
	dram_addr_t exp_addr;
	int h, v, m, mh, mv;
	pix_idx_t idx;
	color_t col;
	logic ehs, evs;

	video_top #(
		.h_active  (h_active),
		.h_total   (h_total),
		.hsync_beg (hsync_beg),
		.hsync_len (hsync_len),
		.v_active  (v_active),
		.v_total   (v_total),
		.vsync_beg (vsync_beg),
		.vsync_len (vsync_len)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.port_wr    (port_wr),
		.port_addr  (port_addr),
		.port_data  (port_data),
		.cram_we    (cram_we),
		.cram_addr  (cram_addr),
		.cram_data  (cram_data),
		.video_addr (video_addr),
		.video_go   (video_go),
		.video_next (video_next),
		.dram_rdata (dram_rdata),
		.vred       (vred),
		.vgrn       (vgrn),
		.vblu       (vblu),
		.hsync      (hsync),
		.vsync      (vsync),
		.int_start  (int_start)
	);

	always #4 clk = ~clk;

	// dram answers after 1 to 3 cycles
	always @(posedge clk) begin
		if (!rst_n) begin
			video_next <= 1'b0;
			pending <= 1'b0;
		end else if (video_next) begin
			video_next <= 1'b0;
		end else if (video_go) begin
			w = pending ? wait_cnt : $urandom % 3;
			if (w == 0) begin
				// the fetch is for the line after the current one
				fv = ((pos / h_total) + 1) % v_total;
				exp_addr = {vpage_sh[5:0], 9'(gy_sh + fv), 6'(fetch_k)};
				check_addr("video_addr", exp_addr, video_addr);
				fetch_k++;
				video_next <= 1'b1;
				dram_rdata <= video_addr[15:0] ^ 16'h5a3c;
				pending <= 1'b0;
			end else begin
				pending <= 1'b1;
				wait_cnt <= w - 1;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("checks: %0d errors: %0d", checks, errors + 1);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic color_t pal_color(input int i);
		return color_t'(i * 133) ^ 15'h3c69;
	endfunction

	// pixel index from the dram data pattern and the page layout
	function automatic pix_idx_t expect_index(input int hp, input int vp);
		logic [8:0] row;
		dram_addr_t addr;
		word_t data;
		row = gy_sh + 9'(vp);
		addr = {vpage_sh[5:0], row, 6'(hp / 4)};
		data = addr[15:0] ^ 16'h5a3c;
		return {palsel_sh, data[15 - 4 * (hp % 4) -: 4]};
	endfunction

	task automatic check_color(input string name, input color_t exp,
			input logic [1:0] r, input logic [1:0] g, input logic [1:0] b);
		checks++;
		if ({r, g, b} !== {exp[14:13], exp[9:8], exp[4:3]}) begin
			errors++;
			$display("[FAIL] %s at pos %0d: expected %h got %h", name, pos,
				{exp[14:13], exp[9:8], exp[4:3]}, {r, g, b});
		end
	endtask

	task automatic check_sync(input string name, input logic exp_hs, input logic exp_vs,
			input logic act_hs, input logic act_vs);
		checks++;
		if ({act_hs, act_vs} !== {exp_hs, exp_vs}) begin
			errors++;
			$display("[FAIL] %s at pos %0d: expected %h got %h", name, pos,
				{exp_hs, exp_vs}, {act_hs, act_vs});
		end
	endtask

	task automatic check_pulse(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s at pos %0d: expected %h got %h", name, pos, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input dram_addr_t exp,
			input dram_addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s at pos %0d: expected %h got %h", name, pos, exp, act);
		end
	endtask

	// outputs after edge n carry counter cycle n-4
	always @(negedge clk) begin
		if (armed)
			pos = pos + 1;
		if (rst_n)
			armed = 1'b1;
		if (pos < 0) begin
			check_color("dac", '0, vred, vgrn, vblu);
			check_sync("hsync/vsync", 1'b1, 1'b1, hsync, vsync);
			check_pulse("int_start", 1'b0, int_start);
			check_pulse("video_go", 1'b0, video_go);
		end else begin
			h = pos % h_total;
			v = (pos / h_total) % v_total;
			if (h == 0)
				fetch_k = 0;
			check_pulse("int_start", h == hint_seen && v == vint_seen, int_start);
			hint_seen = hint_sh;
			vint_seen = vint_sh;
			if (int_start && pos / frame_cycles < 8)
				pulses[pos / frame_cycles]++;
			if (h < h_active && v < v_active)
				idx = expect_index(h, v);
			else
				idx = border_sh;
			col_q.push_back(pal_color(idx));
			if (pos < 4) begin
				check_color("dac", '0, vred, vgrn, vblu);
				check_sync("hsync/vsync", 1'b1, 1'b1, hsync, vsync);
			end else begin
				m = pos - 4;
				mh = m % h_total;
				mv = (m / h_total) % v_total;
				ehs = !(mh >= hsync_beg && mh < hsync_beg + hsync_len);
				evs = !(mv >= vsync_beg && mv < vsync_beg + vsync_len);
				check_sync("hsync/vsync", ehs, evs, hsync, vsync);
				col = col_q.pop_front();
				if (!ehs || !evs)
					col = '0;
				// palette is loaded during frame 0
				if (m >= frame_cycles)
					check_color("dac", col, vred, vgrn, vblu);
				if (mh < h_active && mv < v_active) begin
					if (m / frame_cycles == 6)
						snap[mv * h_active + mh] = {vred, 3'b000, vgrn, 3'b000, vblu, 3'b000};
					else if (m / frame_cycles == 7)
						check_color("repeat frame", snap[mv * h_active + mh], vred, vgrn, vblu);
				end
			end
		end
	end

	task automatic wait_line(input int frame, input int line);
		while (pos < frame * frame_cycles + line * h_total)
			@(posedge clk);
	endtask

	task automatic write_port(input reg_addr_t addr, input logic [7:0] data);
		@(posedge clk);
		port_wr <= 1'b1;
		port_addr <= addr;
		port_data <= data;
		@(posedge clk);
		port_wr <= 1'b0;
		// register took the write on this edge
		case (addr)
			reg_border: border_sh = data;
			reg_vpage: vpage_sh = data;
			reg_palsel: palsel_sh = data[3:0];
			reg_gy_offsl: gy_sh[7:0] = data;
			reg_gy_offsh: gy_sh[8] = data[0];
			reg_hint_beg: hint_sh = data;
			reg_vint_begl: vint_sh[7:0] = data;
			reg_vint_begh: vint_sh[8] = data[0];
			default: ;
		endcase
	endtask

	task automatic load_palette;
		for (int i = 0; i < 256; i++) begin
			@(posedge clk);
			cram_we <= 1'b1;
			cram_addr <= pix_idx_t'(i);
			cram_data <= pal_color(i);
		end
		@(posedge clk);
		cram_we <= 1'b0;
	endtask

	task automatic set_view(input logic [7:0] page, input logic [8:0] offs,
			input logic [3:0] sel);
		write_port(reg_vpage, page);
		write_port(reg_gy_offsl, offs[7:0]);
		write_port(reg_gy_offsh, {7'd0, offs[8]});
		write_port(reg_palsel, {4'd0, sel});
	endtask

	task automatic border_test;
		wait_line(0, 9);
		write_port(reg_border, 8'h1c);
		// change in the middle of a displayed frame
		wait_line(1, 4);
		write_port(reg_border, 8'h93);
	endtask

	task automatic pixel_test;
		wait_line(1, 8);
		set_view(8'h25, 9'h1f3, 4'ha);
		wait_line(2, 8);
		set_view(8'h0c, 9'h007, 4'h3);
	endtask

	task automatic interrupt_test;
		wait_line(3, 8);
		write_port(reg_hint_beg, 8'h11);
		write_port(reg_vint_begl, 8'h05);
		write_port(reg_vint_begh, 8'h00);
		// line 0x10a never comes, so frame 5 waits for the next write
		wait_line(4, 8);
		write_port(reg_vint_begl, 8'h0a);
		write_port(reg_vint_begh, 8'h01);
		wait_line(5, 8);
		write_port(reg_vint_begh, 8'h00);
		wait_line(7, 0);
		for (int f = 4; f < 7; f++) begin
			checks++;
			if (pulses[f] != 1) begin
				errors++;
				$display("[FAIL] int_start pulses in frame %0d: expected %h got %h",
					f, 1, pulses[f]);
			end
		end
	endtask

	task automatic repeat_test;
		// frames 6 and 7 are compared by the monitor
		wait_line(7, 8);
	endtask

	initial begin
		void'($urandom(32'h4ba0));
		rst_n = 1'b0;
		port_wr = 1'b0;
		port_addr = '0;
		port_data = '0;
		cram_we = 1'b0;
		cram_addr = '0;
		cram_data = '0;
		for (int f = 0; f < 8; f++)
			pulses[f] = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		load_palette();
		border_test();
		pixel_test();
		interrupt_test();
		repeat_test();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
logic/video_pkg.sv
logic/video_ports.sv
logic/video_sync.sv
logic/video_fetch.sv
logic/video_dpram.sv
logic/video_render.sv
logic/video_out.sv
logic/video_top.sv
testbench/tb_video_top.sv

// File: Bender.yml
package:
  name: video_top

sources:
  - logic/video_pkg.sv
  - logic/video_ports.sv
  - logic/video_sync.sv
  - logic/video_fetch.sv
  - logic/video_dpram.sv
  - logic/video_render.sv
  - logic/video_out.sv
  - logic/video_top.sv
  - target: simulation
    files:
      - testbench/tb_video_top.sv
